//--- include/axi_ic_defines.svh
`ifndef AXI_IC_DEFINES_SVH
`define AXI_IC_DEFINES_SVH

// ========================================
// Bus widths
// ========================================
`define AXI_ID_BITS       4
`define AXI_IDS_BITS      8
`define AXI_ADDR_BITS     32
`define AXI_DATA_BITS     32
`define AXI_STRB_BITS     4
`define AXI_LEN_BITS      4
`define AXI_SIZE_BITS     3

// ========================================
// Decode and response codes
// ========================================
// Address bit that picks slave 1 over slave 0
`define AXI_SLAVE_SEL_BIT 16

`define AXI_RESP_OKAY     2'b00

`endif

//--- hw/axi_ic_pkg.sv
`include "axi_ic_defines.svh"

package axi_ic_pkg;

	// ========================================
	// Channel fields
	// ========================================
	typedef logic [`AXI_ID_BITS-1:0]   id_t;
	typedef logic [`AXI_IDS_BITS-1:0]  sid_t;
	typedef logic [`AXI_ADDR_BITS-1:0] addr_t;
	typedef logic [`AXI_DATA_BITS-1:0] data_t;
	typedef logic [`AXI_STRB_BITS-1:0] strb_t;
	typedef logic [`AXI_LEN_BITS-1:0]  len_t;
	typedef logic [`AXI_SIZE_BITS-1:0] size_t;
	typedef logic [1:0]                burst_t;
	typedef logic [1:0]                resp_t;

	// ========================================
	// Grant states
	// ========================================
	// One grant at a time, named by master, slave and direction
	typedef enum logic [2:0] {
		GNT_IDLE     = 3'd0,
		GNT_M0_S0_RD = 3'd1,
		GNT_M0_S1_RD = 3'd2,
		GNT_M1_S0_RD = 3'd3,
		GNT_M1_S1_RD = 3'd4,
		GNT_M1_S0_WR = 3'd5,
		GNT_M1_S1_WR = 3'd6
	} grant_e;

endpackage

//--- hw/axi_ic_arbiter.sv
`timescale 1ns/10ps
`include "axi_ic_defines.svh"

module axi_ic_arbiter (
	input  logic               ACLK,
	input  logic               ARESETn,
	input  logic               arvalid_m0,
	input  axi_ic_pkg::addr_t  araddr_m0,
	input  logic               arvalid_m1,
	input  axi_ic_pkg::addr_t  araddr_m1,
	input  logic               awvalid_m1,
	input  axi_ic_pkg::addr_t  awaddr_m1,
	input  logic               rvalid_m0,
	input  logic               rready_m0,
	input  logic               rlast_m0,
	input  logic               rvalid_m1,
	input  logic               rready_m1,
	input  logic               rlast_m1,
	input  logic               bvalid_m1,
	input  logic               bready_m1,
	output axi_ic_pkg::grant_e grant
);

	axi_ic_pkg::grant_e grant_nxt;
	logic               txn_done;

	// Closing handshake of the granted transaction
	always_comb
	begin
		case (grant)
			axi_ic_pkg::GNT_M0_S0_RD,
			axi_ic_pkg::GNT_M0_S1_RD:
				txn_done = rvalid_m0 && rready_m0 && rlast_m0;
			axi_ic_pkg::GNT_M1_S0_RD,
			axi_ic_pkg::GNT_M1_S1_RD:
				txn_done = rvalid_m1 && rready_m1 && rlast_m1;
			axi_ic_pkg::GNT_M1_S0_WR,
			axi_ic_pkg::GNT_M1_S1_WR:
				txn_done = bvalid_m1 && bready_m1;
			default:
				txn_done = 1'b0;
		endcase
	end

	// Fixed priority from idle only, so every grant ends in one idle cycle
	always_comb
	begin
		grant_nxt = grant;
		if (grant == axi_ic_pkg::GNT_IDLE)
		begin
			if (arvalid_m0)
			begin
				if (araddr_m0[`AXI_SLAVE_SEL_BIT])
					grant_nxt = axi_ic_pkg::GNT_M0_S1_RD;
				else
					grant_nxt = axi_ic_pkg::GNT_M0_S0_RD;
			end
			else if (arvalid_m1)
			begin
				if (araddr_m1[`AXI_SLAVE_SEL_BIT])
					grant_nxt = axi_ic_pkg::GNT_M1_S1_RD;
				else
					grant_nxt = axi_ic_pkg::GNT_M1_S0_RD;
			end
			else if (awvalid_m1)
			begin
				if (awaddr_m1[`AXI_SLAVE_SEL_BIT])
					grant_nxt = axi_ic_pkg::GNT_M1_S1_WR;
				else
					grant_nxt = axi_ic_pkg::GNT_M1_S0_WR;
			end
		end
		else if (txn_done)
			grant_nxt = axi_ic_pkg::GNT_IDLE;
	end

	always_ff @(posedge ACLK or negedge ARESETn)
	begin
		if (!ARESETn)
			grant <= axi_ic_pkg::GNT_IDLE;
		else
			grant <= grant_nxt;
	end

	a_grant_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		(grant != axi_ic_pkg::GNT_IDLE && !txn_done) |=> grant == $past(grant));

endmodule

//--- hw/axi_ic_read_path.sv
`timescale 1ns/10ps
`include "axi_ic_defines.svh"

module axi_ic_read_path (
	input  axi_ic_pkg::grant_e grant,
	// Master 0
	input  axi_ic_pkg::id_t    arid_m0,
	input  axi_ic_pkg::addr_t  araddr_m0,
	input  axi_ic_pkg::len_t   arlen_m0,
	input  axi_ic_pkg::size_t  arsize_m0,
	input  axi_ic_pkg::burst_t arburst_m0,
	input  logic               arvalid_m0,
	output logic               arready_m0,
	output axi_ic_pkg::id_t    rid_m0,
	output axi_ic_pkg::data_t  rdata_m0,
	output axi_ic_pkg::resp_t  rresp_m0,
	output logic               rlast_m0,
	output logic               rvalid_m0,
	input  logic               rready_m0,
	// Master 1
	input  axi_ic_pkg::id_t    arid_m1,
	input  axi_ic_pkg::addr_t  araddr_m1,
	input  axi_ic_pkg::len_t   arlen_m1,
	input  axi_ic_pkg::size_t  arsize_m1,
	input  axi_ic_pkg::burst_t arburst_m1,
	input  logic               arvalid_m1,
	output logic               arready_m1,
	output axi_ic_pkg::id_t    rid_m1,
	output axi_ic_pkg::data_t  rdata_m1,
	output axi_ic_pkg::resp_t  rresp_m1,
	output logic               rlast_m1,
	output logic               rvalid_m1,
	input  logic               rready_m1,
	// Slave 0
	output axi_ic_pkg::sid_t   arid_s0,
	output axi_ic_pkg::addr_t  araddr_s0,
	output axi_ic_pkg::len_t   arlen_s0,
	output axi_ic_pkg::size_t  arsize_s0,
	output axi_ic_pkg::burst_t arburst_s0,
	output logic               arvalid_s0,
	input  logic               arready_s0,
	input  axi_ic_pkg::sid_t   rid_s0,
	input  axi_ic_pkg::data_t  rdata_s0,
	input  axi_ic_pkg::resp_t  rresp_s0,
	input  logic               rlast_s0,
	input  logic               rvalid_s0,
	output logic               rready_s0,
	// Slave 1
	output axi_ic_pkg::sid_t   arid_s1,
	output axi_ic_pkg::addr_t  araddr_s1,
	output axi_ic_pkg::len_t   arlen_s1,
	output axi_ic_pkg::size_t  arsize_s1,
	output axi_ic_pkg::burst_t arburst_s1,
	output logic               arvalid_s1,
	input  logic               arready_s1,
	input  axi_ic_pkg::sid_t   rid_s1,
	input  axi_ic_pkg::data_t  rdata_s1,
	input  axi_ic_pkg::resp_t  rresp_s1,
	input  logic               rlast_s1,
	input  logic               rvalid_s1,
	output logic               rready_s1
);

	logic to_m0;
	logic to_m1;
	logic to_s0;
	logic to_s1;

	// ========================================
	// Grant decode
	// ========================================
	assign to_m0 = grant == axi_ic_pkg::GNT_M0_S0_RD || grant == axi_ic_pkg::GNT_M0_S1_RD;
	assign to_m1 = grant == axi_ic_pkg::GNT_M1_S0_RD || grant == axi_ic_pkg::GNT_M1_S1_RD;
	assign to_s0 = grant == axi_ic_pkg::GNT_M0_S0_RD || grant == axi_ic_pkg::GNT_M1_S0_RD;
	assign to_s1 = grant == axi_ic_pkg::GNT_M0_S1_RD || grant == axi_ic_pkg::GNT_M1_S1_RD;

	// ========================================
	// AR toward the slaves
	// ========================================
	// Master number goes in the upper ID field
	assign arid_s0    = to_s0 ? {axi_ic_pkg::id_t'(to_m1), to_m1 ? arid_m1 : arid_m0} : '0;
	assign araddr_s0  = to_s0 ? (to_m1 ? araddr_m1 : araddr_m0) : '0;
	assign arlen_s0   = to_s0 ? (to_m1 ? arlen_m1 : arlen_m0) : '0;
	assign arsize_s0  = to_s0 ? (to_m1 ? arsize_m1 : arsize_m0) : '0;
	assign arburst_s0 = to_s0 ? (to_m1 ? arburst_m1 : arburst_m0) : '0;
	assign arvalid_s0 = to_s0 && (to_m1 ? arvalid_m1 : arvalid_m0);
	assign rready_s0  = to_s0 && (to_m1 ? rready_m1 : rready_m0);

	assign arid_s1    = to_s1 ? {axi_ic_pkg::id_t'(to_m1), to_m1 ? arid_m1 : arid_m0} : '0;
	assign araddr_s1  = to_s1 ? (to_m1 ? araddr_m1 : araddr_m0) : '0;
	assign arlen_s1   = to_s1 ? (to_m1 ? arlen_m1 : arlen_m0) : '0;
	assign arsize_s1  = to_s1 ? (to_m1 ? arsize_m1 : arsize_m0) : '0;
	assign arburst_s1 = to_s1 ? (to_m1 ? arburst_m1 : arburst_m0) : '0;
	assign arvalid_s1 = to_s1 && (to_m1 ? arvalid_m1 : arvalid_m0);
	assign rready_s1  = to_s1 && (to_m1 ? rready_m1 : rready_m0);

	// ========================================
	// R back to the masters
	// ========================================
	assign arready_m0 = to_m0 && (to_s1 ? arready_s1 : arready_s0);
	assign rid_m0     = to_m0 ? (to_s1 ? rid_s1[`AXI_ID_BITS-1:0] : rid_s0[`AXI_ID_BITS-1:0]) : '0;
	assign rdata_m0   = to_m0 ? (to_s1 ? rdata_s1 : rdata_s0) : '0;
	assign rresp_m0   = to_m0 ? (to_s1 ? rresp_s1 : rresp_s0) : '0;
	assign rlast_m0   = to_m0 && (to_s1 ? rlast_s1 : rlast_s0);
	assign rvalid_m0  = to_m0 && (to_s1 ? rvalid_s1 : rvalid_s0);

	assign arready_m1 = to_m1 && (to_s1 ? arready_s1 : arready_s0);
	assign rid_m1     = to_m1 ? (to_s1 ? rid_s1[`AXI_ID_BITS-1:0] : rid_s0[`AXI_ID_BITS-1:0]) : '0;
	assign rdata_m1   = to_m1 ? (to_s1 ? rdata_s1 : rdata_s0) : '0;
	assign rresp_m1   = to_m1 ? (to_s1 ? rresp_s1 : rresp_s0) : '0;
	assign rlast_m1   = to_m1 && (to_s1 ? rlast_s1 : rlast_s0);
	assign rvalid_m1  = to_m1 && (to_s1 ? rvalid_s1 : rvalid_s0);

	a_ar_one_slave: assert final (!(arvalid_s0 && arvalid_s1))
		else $error("AR request driven to both slaves");

endmodule

//--- hw/axi_ic_write_path.sv
`timescale 1ns/10ps
`include "axi_ic_defines.svh"

module axi_ic_write_path (
	input  axi_ic_pkg::grant_e grant,
	// Master 1
	input  axi_ic_pkg::id_t    awid_m1,
	input  axi_ic_pkg::addr_t  awaddr_m1,
	input  axi_ic_pkg::len_t   awlen_m1,
	input  axi_ic_pkg::size_t  awsize_m1,
	input  axi_ic_pkg::burst_t awburst_m1,
	input  logic               awvalid_m1,
	output logic               awready_m1,
	input  axi_ic_pkg::data_t  wdata_m1,
	input  axi_ic_pkg::strb_t  wstrb_m1,
	input  logic               wlast_m1,
	input  logic               wvalid_m1,
	output logic               wready_m1,
	output axi_ic_pkg::id_t    bid_m1,
	output axi_ic_pkg::resp_t  bresp_m1,
	output logic               bvalid_m1,
	input  logic               bready_m1,
	// Slave 0
	output axi_ic_pkg::sid_t   awid_s0,
	output axi_ic_pkg::addr_t  awaddr_s0,
	output axi_ic_pkg::len_t   awlen_s0,
	output axi_ic_pkg::size_t  awsize_s0,
	output axi_ic_pkg::burst_t awburst_s0,
	output logic               awvalid_s0,
	input  logic               awready_s0,
	output axi_ic_pkg::data_t  wdata_s0,
	output axi_ic_pkg::strb_t  wstrb_s0,
	output logic               wlast_s0,
	output logic               wvalid_s0,
	input  logic               wready_s0,
	input  axi_ic_pkg::sid_t   bid_s0,
	input  axi_ic_pkg::resp_t  bresp_s0,
	input  logic               bvalid_s0,
	output logic               bready_s0,
	// Slave 1
	output axi_ic_pkg::sid_t   awid_s1,
	output axi_ic_pkg::addr_t  awaddr_s1,
	output axi_ic_pkg::len_t   awlen_s1,
	output axi_ic_pkg::size_t  awsize_s1,
	output axi_ic_pkg::burst_t awburst_s1,
	output logic               awvalid_s1,
	input  logic               awready_s1,
	output axi_ic_pkg::data_t  wdata_s1,
	output axi_ic_pkg::strb_t  wstrb_s1,
	output logic               wlast_s1,
	output logic               wvalid_s1,
	input  logic               wready_s1,
	input  axi_ic_pkg::sid_t   bid_s1,
	input  axi_ic_pkg::resp_t  bresp_s1,
	input  logic               bvalid_s1,
	output logic               bready_s1
);

	logic to_s0;
	logic to_s1;

	assign to_s0 = grant == axi_ic_pkg::GNT_M1_S0_WR;
	assign to_s1 = grant == axi_ic_pkg::GNT_M1_S1_WR;

	// ========================================
	// AW and W toward the slaves
	// ========================================
	// Only master 1 writes, so the upper ID field is always 1
	assign awid_s0    = to_s0 ? {axi_ic_pkg::id_t'(1'b1), awid_m1} : '0;
	assign awaddr_s0  = to_s0 ? awaddr_m1 : '0;
	assign awlen_s0   = to_s0 ? awlen_m1 : '0;
	assign awsize_s0  = to_s0 ? awsize_m1 : '0;
	assign awburst_s0 = to_s0 ? awburst_m1 : '0;
	assign awvalid_s0 = to_s0 && awvalid_m1;
	assign wdata_s0   = to_s0 ? wdata_m1 : '0;
	assign wstrb_s0   = to_s0 ? wstrb_m1 : '0;
	assign wlast_s0   = to_s0 && wlast_m1;
	assign wvalid_s0  = to_s0 && wvalid_m1;
	assign bready_s0  = to_s0 && bready_m1;

	assign awid_s1    = to_s1 ? {axi_ic_pkg::id_t'(1'b1), awid_m1} : '0;
	assign awaddr_s1  = to_s1 ? awaddr_m1 : '0;
	assign awlen_s1   = to_s1 ? awlen_m1 : '0;
	assign awsize_s1  = to_s1 ? awsize_m1 : '0;
	assign awburst_s1 = to_s1 ? awburst_m1 : '0;
	assign awvalid_s1 = to_s1 && awvalid_m1;
	assign wdata_s1   = to_s1 ? wdata_m1 : '0;
	assign wstrb_s1   = to_s1 ? wstrb_m1 : '0;
	assign wlast_s1   = to_s1 && wlast_m1;
	assign wvalid_s1  = to_s1 && wvalid_m1;
	assign bready_s1  = to_s1 && bready_m1;

	// ========================================
	// Ready and B back to master 1
	// ========================================
	assign awready_m1 = (to_s0 && awready_s0) || (to_s1 && awready_s1);
	assign wready_m1  = (to_s0 && wready_s0) || (to_s1 && wready_s1);
	assign bvalid_m1  = (to_s0 && bvalid_s0) || (to_s1 && bvalid_s1);
	assign bresp_m1   = to_s1 ? bresp_s1 : (to_s0 ? bresp_s0 : '0);
	// Lower ID field only
	assign bid_m1     = to_s1 ? bid_s1[`AXI_ID_BITS-1:0]
		: (to_s0 ? bid_s0[`AXI_ID_BITS-1:0] : '0);

	a_w_s0_granted: assert final (!wvalid_s0 || grant == axi_ic_pkg::GNT_M1_S0_WR)
		else $error("W beat on slave 0 without its write grant");
	a_w_s1_granted: assert final (!wvalid_s1 || grant == axi_ic_pkg::GNT_M1_S1_WR)
		else $error("W beat on slave 1 without its write grant");

endmodule

//--- hw/axi_interconnect.sv
`timescale 1ns/10ps

module axi_interconnect (
	input  logic               ACLK,
	input  logic               ARESETn,
	// ========================================
	// Master 0, read only
	// ========================================
	input  axi_ic_pkg::id_t    arid_m0,
	input  axi_ic_pkg::addr_t  araddr_m0,
	input  axi_ic_pkg::len_t   arlen_m0,
	input  axi_ic_pkg::size_t  arsize_m0,
	input  axi_ic_pkg::burst_t arburst_m0,
	input  logic               arvalid_m0,
	output logic               arready_m0,
	output axi_ic_pkg::id_t    rid_m0,
	output axi_ic_pkg::data_t  rdata_m0,
	output axi_ic_pkg::resp_t  rresp_m0,
	output logic               rlast_m0,
	output logic               rvalid_m0,
	input  logic               rready_m0,
	// ========================================
	// Master 1
	// ========================================
	input  axi_ic_pkg::id_t    arid_m1,
	input  axi_ic_pkg::addr_t  araddr_m1,
	input  axi_ic_pkg::len_t   arlen_m1,
	input  axi_ic_pkg::size_t  arsize_m1,
	input  axi_ic_pkg::burst_t arburst_m1,
	input  logic               arvalid_m1,
	output logic               arready_m1,
	output axi_ic_pkg::id_t    rid_m1,
	output axi_ic_pkg::data_t  rdata_m1,
	output axi_ic_pkg::resp_t  rresp_m1,
	output logic               rlast_m1,
	output logic               rvalid_m1,
	input  logic               rready_m1,
	input  axi_ic_pkg::id_t    awid_m1,
	input  axi_ic_pkg::addr_t  awaddr_m1,
	input  axi_ic_pkg::len_t   awlen_m1,
	input  axi_ic_pkg::size_t  awsize_m1,
	input  axi_ic_pkg::burst_t awburst_m1,
	input  logic               awvalid_m1,
	output logic               awready_m1,
	input  axi_ic_pkg::data_t  wdata_m1,
	input  axi_ic_pkg::strb_t  wstrb_m1,
	input  logic               wlast_m1,
	input  logic               wvalid_m1,
	output logic               wready_m1,
	output axi_ic_pkg::id_t    bid_m1,
	output axi_ic_pkg::resp_t  bresp_m1,
	output logic               bvalid_m1,
	input  logic               bready_m1,
	// ========================================
	// Slave 0
	// ========================================
	output axi_ic_pkg::sid_t   arid_s0,
	output axi_ic_pkg::addr_t  araddr_s0,
	output axi_ic_pkg::len_t   arlen_s0,
	output axi_ic_pkg::size_t  arsize_s0,
	output axi_ic_pkg::burst_t arburst_s0,
	output logic               arvalid_s0,
	input  logic               arready_s0,
	input  axi_ic_pkg::sid_t   rid_s0,
	input  axi_ic_pkg::data_t  rdata_s0,
	input  axi_ic_pkg::resp_t  rresp_s0,
	input  logic               rlast_s0,
	input  logic               rvalid_s0,
	output logic               rready_s0,
	output axi_ic_pkg::sid_t   awid_s0,
	output axi_ic_pkg::addr_t  awaddr_s0,
	output axi_ic_pkg::len_t   awlen_s0,
	output axi_ic_pkg::size_t  awsize_s0,
	output axi_ic_pkg::burst_t awburst_s0,
	output logic               awvalid_s0,
	input  logic               awready_s0,
	output axi_ic_pkg::data_t  wdata_s0,
	output axi_ic_pkg::strb_t  wstrb_s0,
	output logic               wlast_s0,
	output logic               wvalid_s0,
	input  logic               wready_s0,
	input  axi_ic_pkg::sid_t   bid_s0,
	input  axi_ic_pkg::resp_t  bresp_s0,
	input  logic               bvalid_s0,
	output logic               bready_s0,
	// ========================================
	// Slave 1
	// ========================================
	output axi_ic_pkg::sid_t   arid_s1,
	output axi_ic_pkg::addr_t  araddr_s1,
	output axi_ic_pkg::len_t   arlen_s1,
	output axi_ic_pkg::size_t  arsize_s1,
	output axi_ic_pkg::burst_t arburst_s1,
	output logic               arvalid_s1,
	input  logic               arready_s1,
	input  axi_ic_pkg::sid_t   rid_s1,
	input  axi_ic_pkg::data_t  rdata_s1,
	input  axi_ic_pkg::resp_t  rresp_s1,
	input  logic               rlast_s1,
	input  logic               rvalid_s1,
	output logic               rready_s1,
	output axi_ic_pkg::sid_t   awid_s1,
	output axi_ic_pkg::addr_t  awaddr_s1,
	output axi_ic_pkg::len_t   awlen_s1,
	output axi_ic_pkg::size_t  awsize_s1,
	output axi_ic_pkg::burst_t awburst_s1,
	output logic               awvalid_s1,
	input  logic               awready_s1,
	output axi_ic_pkg::data_t  wdata_s1,
	output axi_ic_pkg::strb_t  wstrb_s1,
	output logic               wlast_s1,
	output logic               wvalid_s1,
	input  logic               wready_s1,
	input  axi_ic_pkg::sid_t   bid_s1,
	input  axi_ic_pkg::resp_t  bresp_s1,
	input  logic               bvalid_s1,
	output logic               bready_s1
);

	// Single grant shared by both paths
	axi_ic_pkg::grant_e grant;

	axi_ic_arbiter arbiter_inst (.*);

	axi_ic_read_path read_path_inst (.*);

	axi_ic_write_path write_path_inst (.*);

endmodule

//--- verif/axi_ic_slave_bfm.sv
`timescale 1ns/10ps
`include "axi_ic_defines.svh"

module axi_ic_slave_bfm #(
	parameter int seed_init = 1
) (
	input  logic               ACLK,
	input  logic               ARESETn,
	input  axi_ic_pkg::sid_t   arid,
	input  axi_ic_pkg::addr_t  araddr,
	input  axi_ic_pkg::len_t   arlen,
	input  logic               arvalid,
	output logic               arready,
	output axi_ic_pkg::sid_t   rid,
	output axi_ic_pkg::data_t  rdata,
	output axi_ic_pkg::resp_t  rresp,
	output logic               rlast,
	output logic               rvalid,
	input  logic               rready,
	input  axi_ic_pkg::sid_t   awid,
	input  axi_ic_pkg::addr_t  awaddr,
	input  axi_ic_pkg::len_t   awlen,
	input  logic               awvalid,
	output logic               awready,
	input  axi_ic_pkg::data_t  wdata,
	input  axi_ic_pkg::strb_t  wstrb,
	input  logic               wvalid,
	output logic               wready,
	output axi_ic_pkg::sid_t   bid,
	output axi_ic_pkg::resp_t  bresp,
	output logic               bvalid,
	input  logic               bready,
	output logic               stall_err
);

	localparam int wait_limit = 1000;

	logic [31:0]       mem [logic [29:0]];
	integer            seed;
	axi_ic_pkg::sid_t  id_q;
	axi_ic_pkg::addr_t addr_q;
	axi_ic_pkg::len_t  len_q;

	// Unwritten words read back a pattern of their own address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h9e37_79b9;
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] addr);
		return mem.exists(addr[31:2]) ? mem[addr[31:2]] : fill_word(addr);
	endfunction

	// Zero to two idle cycles, from just after one rising edge to the next
	task automatic stall();
		int n;
		n = {$random(seed)} % 3;
		repeat (n)
		begin
			@(posedge ACLK);
			#1;
		end
	endtask

	task automatic serve_read();
		int n;
		@(posedge ACLK);
		#1;
		stall();
		arready = 1'b1;
		@(negedge ACLK);
		id_q = arid;
		addr_q = araddr;
		len_q = arlen;
		@(posedge ACLK);
		#1;
		arready = 1'b0;
		for (int i = 0; i <= len_q; i++)
		begin
			stall();
			rvalid = 1'b1;
			rid = id_q;
			rdata = read_word(addr_q + 4 * i);
			rresp = `AXI_RESP_OKAY;
			rlast = (i == len_q);
			n = 0;
			do
			begin
				@(negedge ACLK);
				n++;
			end while (!rready && n < wait_limit);
			if (!rready)
				stall_err = 1'b1;
			@(posedge ACLK);
			#1;
			rvalid = 1'b0;
			rlast = 1'b0;
		end
	endtask

	task automatic serve_write();
		int n;
		logic [31:0] word;
		@(posedge ACLK);
		#1;
		stall();
		awready = 1'b1;
		@(negedge ACLK);
		id_q = awid;
		addr_q = awaddr;
		len_q = awlen;
		@(posedge ACLK);
		#1;
		awready = 1'b0;
		for (int i = 0; i <= len_q; i++)
		begin
			stall();
			wready = 1'b1;
			n = 0;
			do
			begin
				@(negedge ACLK);
				n++;
			end while (!wvalid && n < wait_limit);
			if (!wvalid)
				stall_err = 1'b1;
			// Byte lanes merge into the stored word
			word = read_word(addr_q + 4 * i);
			for (int b = 0; b < 4; b++)
				if (wstrb[b])
					word[8*b +: 8] = wdata[8*b +: 8];
			mem[(addr_q + 4 * i) >> 2] = word;
			@(posedge ACLK);
			#1;
			wready = 1'b0;
		end
		stall();
		bvalid = 1'b1;
		bid = id_q;
		bresp = `AXI_RESP_OKAY;
		n = 0;
		do
		begin
			@(negedge ACLK);
			n++;
		end while (!bready && n < wait_limit);
		if (!bready)
			stall_err = 1'b1;
		@(posedge ACLK);
		#1;
		bvalid = 1'b0;
	endtask

	initial
	begin
		seed = seed_init;
		stall_err = 1'b0;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rid = '0;
		rdata = '0;
		rresp = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bid = '0;
		bresp = '0;
		@(posedge ARESETn);
		forever
		begin
			@(negedge ACLK);
			if (arvalid)
				serve_read();
			else if (awvalid)
				serve_write();
		end
	end

endmodule

//--- verif/axi_interconnect_tb.sv
`timescale 1ns/10ps
`include "axi_ic_defines.svh"

module axi_interconnect_tb;

	localparam int seed_base  = 32'h13aaaf75;
	localparam int wait_limit = 1000;

	logic ACLK;
	logic ARESETn;
	axi_ic_pkg::id_t    arid_m0, rid_m0, arid_m1, rid_m1, awid_m1, bid_m1;
	axi_ic_pkg::sid_t   arid_s0, rid_s0, awid_s0, bid_s0, arid_s1, rid_s1, awid_s1, bid_s1;
	axi_ic_pkg::addr_t  araddr_m0, araddr_m1, awaddr_m1;
	axi_ic_pkg::addr_t  araddr_s0, awaddr_s0, araddr_s1, awaddr_s1;
	axi_ic_pkg::data_t  rdata_m0, rdata_m1, wdata_m1, rdata_s0, wdata_s0, rdata_s1, wdata_s1;
	axi_ic_pkg::len_t   arlen_m0, arlen_m1, awlen_m1, arlen_s0, awlen_s0, arlen_s1, awlen_s1;
	axi_ic_pkg::size_t  arsize_m0, arsize_m1, awsize_m1;
	axi_ic_pkg::size_t  arsize_s0, awsize_s0, arsize_s1, awsize_s1;
	axi_ic_pkg::burst_t arburst_m0, arburst_m1, awburst_m1;
	axi_ic_pkg::burst_t arburst_s0, awburst_s0, arburst_s1, awburst_s1;
	axi_ic_pkg::resp_t  rresp_m0, rresp_m1, bresp_m1, rresp_s0, bresp_s0, rresp_s1, bresp_s1;
	axi_ic_pkg::strb_t  wstrb_m1, wstrb_s0, wstrb_s1;
	logic arvalid_m0, arready_m0, rlast_m0, rvalid_m0, rready_m0;
	logic arvalid_m1, arready_m1, rlast_m1, rvalid_m1, rready_m1;
	logic awvalid_m1, awready_m1, wlast_m1, wvalid_m1, wready_m1, bvalid_m1, bready_m1;
	logic arvalid_s0, arready_s0, rlast_s0, rvalid_s0, rready_s0, awvalid_s0, awready_s0;
	logic wlast_s0, wvalid_s0, wready_s0, bvalid_s0, bready_s0;
	logic arvalid_s1, arready_s1, rlast_s1, rvalid_s1, rready_s1, awvalid_s1, awready_s1;
	logic wlast_s1, wvalid_s1, wready_s1, bvalid_s1, bready_s1;
	logic stall_err_s0, stall_err_s1;

	integer      seed;
	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          tests_failed;
	logic [31:0] model0 [logic [29:0]];
	logic [31:0] model1 [logic [29:0]];
	logic [31:0] wr_addr[$];
	logic [3:0]  wr_len[$];

	axi_interconnect axi_interconnect_inst (.*);

	axi_ic_slave_bfm #(.seed_init(seed_base + 1)) slave0_inst (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.arid(arid_s0), .araddr(araddr_s0), .arlen(arlen_s0),
		.arvalid(arvalid_s0), .arready(arready_s0),
		.rid(rid_s0), .rdata(rdata_s0), .rresp(rresp_s0), .rlast(rlast_s0),
		.rvalid(rvalid_s0), .rready(rready_s0),
		.awid(awid_s0), .awaddr(awaddr_s0), .awlen(awlen_s0),
		.awvalid(awvalid_s0), .awready(awready_s0),
		.wdata(wdata_s0), .wstrb(wstrb_s0), .wvalid(wvalid_s0), .wready(wready_s0),
		.bid(bid_s0), .bresp(bresp_s0), .bvalid(bvalid_s0), .bready(bready_s0),
		.stall_err(stall_err_s0)
	);

	axi_ic_slave_bfm #(.seed_init(seed_base + 2)) slave1_inst (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.arid(arid_s1), .araddr(araddr_s1), .arlen(arlen_s1),
		.arvalid(arvalid_s1), .arready(arready_s1),
		.rid(rid_s1), .rdata(rdata_s1), .rresp(rresp_s1), .rlast(rlast_s1),
		.rvalid(rvalid_s1), .rready(rready_s1),
		.awid(awid_s1), .awaddr(awaddr_s1), .awlen(awlen_s1),
		.awvalid(awvalid_s1), .awready(awready_s1),
		.wdata(wdata_s1), .wstrb(wstrb_s1), .wvalid(wvalid_s1), .wready(wready_s1),
		.bid(bid_s1), .bresp(bresp_s1), .bvalid(bvalid_s1), .bready(bready_s1),
		.stall_err(stall_err_s1)
	);

	initial
	begin
		ACLK = 1'b0;
		forever
			#10 ACLK = ~ACLK;
	end

	// ========================================
	// Helpers
	// ========================================
	function automatic int unsigned rand_below(input int unsigned n);
		return {$random(seed)} % n;
	endfunction

	// Same pattern the slave memories return for unwritten words
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h9e37_79b9;
	endfunction

	function automatic logic [31:0] model_read(input logic sel, input logic [31:0] addr);
		if (sel)
			return model1.exists(addr[31:2]) ? model1[addr[31:2]] : fill_word(addr);
		return model0.exists(addr[31:2]) ? model0[addr[31:2]] : fill_word(addr);
	endfunction

	function automatic logic [31:0] rand_addr(input logic sel);
		return ({$random(seed)} & 32'h0000_0ffc) | (32'(sel) << `AXI_SLAVE_SEL_BIT);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
			test_errors++;
		end
	endtask

	task automatic abort_run(input string what);
		$display("Timeout waiting for %s at %0t", what, $time);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		total_errors += test_errors;
		$display("Test %0d %s: %s (%0d errors)", tests_run, name,
			test_errors == 0 ? "ok" : "failing", test_errors);
		test_errors = 0;
	endtask

	task automatic check_idle_outputs();
		check_val("slave-side VALID/READY", {arvalid_s0, arvalid_s1, awvalid_s0, awvalid_s1,
			wvalid_s0, wvalid_s1, rready_s0, rready_s1, bready_s0, bready_s1}, 0);
		check_val("master-side VALID/READY", {arready_m0, arready_m1, awready_m1, wready_m1,
			rvalid_m0, rvalid_m1, bvalid_m1}, 0);
	endtask

	// Unselected slave and ungranted master stay quiet
	task automatic check_isolation(input int m, input logic sel, input logic wr);
		check_val(sel ? "arvalid_s0" : "arvalid_s1", sel ? arvalid_s0 : arvalid_s1, 0);
		check_val(sel ? "awvalid_s0" : "awvalid_s1", sel ? awvalid_s0 : awvalid_s1, 0);
		check_val(sel ? "wvalid_s0" : "wvalid_s1", sel ? wvalid_s0 : wvalid_s1, 0);
		if (m == 0)
			check_val("m1 rvalid/arready/bvalid", {rvalid_m1, arready_m1, bvalid_m1}, 0);
		else
			check_val("m0 rvalid/arready", {rvalid_m0, arready_m0}, 0);
		if (wr)
			check_val("rvalid_m1", rvalid_m1, 0);
		else
			check_val("bvalid_m1/awready_m1", {bvalid_m1, awready_m1}, 0);
	endtask

	// ========================================
	// Master transactions
	// ========================================
	// Each starts and ends 1 ns after a rising edge
	task automatic write_burst(input logic [31:0] addr, input logic [3:0] id,
		input logic [3:0] len);
		logic sel;
		logic [31:0] data;
		logic done;
		int n;
		sel = addr[`AXI_SLAVE_SEL_BIT];
		awid_m1 = id;
		awaddr_m1 = addr;
		awlen_m1 = len;
		awsize_m1 = 3'd2;
		awburst_m1 = 2'b01;
		awvalid_m1 = 1'b1;
		n = 0;
		do
		begin
			@(negedge ACLK);
			n++;
			check_isolation(1, sel, 1'b1);
		end while (!awready_m1 && n < wait_limit);
		if (!awready_m1)
			abort_run("awready_m1");
		check_val(sel ? "awid_s1" : "awid_s0", sel ? awid_s1 : awid_s0, {4'h1, id});
		check_val(sel ? "awaddr_s1" : "awaddr_s0", sel ? awaddr_s1 : awaddr_s0, addr);
		check_val(sel ? "awlen_s1" : "awlen_s0", sel ? awlen_s1 : awlen_s0, len);
		check_val(sel ? "awsize_s1" : "awsize_s0", sel ? awsize_s1 : awsize_s0, 3'd2);
		check_val(sel ? "awburst_s1" : "awburst_s0", sel ? awburst_s1 : awburst_s0, 2'b01);
		@(posedge ACLK);
		#1;
		awvalid_m1 = 1'b0;
		for (int i = 0; i <= len; i++)
		begin
			data = $random(seed);
			wdata_m1 = data;
			wstrb_m1 = 4'hf;
			wlast_m1 = (i == len);
			wvalid_m1 = 1'b1;
			n = 0;
			do
			begin
				@(negedge ACLK);
				n++;
				check_isolation(1, sel, 1'b1);
			end while (!wready_m1 && n < wait_limit);
			if (!wready_m1)
				abort_run("wready_m1");
			check_val(sel ? "wdata_s1" : "wdata_s0", sel ? wdata_s1 : wdata_s0, data);
			check_val(sel ? "wstrb_s1" : "wstrb_s0", sel ? wstrb_s1 : wstrb_s0, 4'hf);
			check_val(sel ? "wlast_s1" : "wlast_s0", sel ? wlast_s1 : wlast_s0, i == len);
			if (sel)
				model1[(addr + 4 * i) >> 2] = data;
			else
				model0[(addr + 4 * i) >> 2] = data;
			@(posedge ACLK);
			#1;
		end
		wvalid_m1 = 1'b0;
		wlast_m1 = 1'b0;
		bready_m1 = rand_below(2);
		done = 1'b0;
		n = 0;
		while (!done)
		begin
			@(negedge ACLK);
			n++;
			if (n > wait_limit)
				abort_run("bvalid_m1");
			check_isolation(1, sel, 1'b1);
			done = bvalid_m1 && bready_m1;
			if (done)
			begin
				check_val("bid_m1", bid_m1, id);
				check_val("bresp_m1", bresp_m1, `AXI_RESP_OKAY);
			end
			@(posedge ACLK);
			#1;
			bready_m1 = rand_below(2);
		end
		bready_m1 = 1'b0;
		wr_addr.push_back(addr);
		wr_len.push_back(len);
	endtask

	task automatic read_burst(input int m, input logic [31:0] addr, input logic [3:0] id,
		input logic [3:0] len);
		logic sel;
		logic hs;
		int n;
		int beat;
		sel = addr[`AXI_SLAVE_SEL_BIT];
		if (m == 0)
		begin
			arid_m0 = id;
			araddr_m0 = addr;
			arlen_m0 = len;
			arsize_m0 = 3'd2;
			arburst_m0 = 2'b01;
			arvalid_m0 = 1'b1;
		end
		else
		begin
			arid_m1 = id;
			araddr_m1 = addr;
			arlen_m1 = len;
			arsize_m1 = 3'd2;
			arburst_m1 = 2'b01;
			arvalid_m1 = 1'b1;
		end
		n = 0;
		do
		begin
			@(negedge ACLK);
			n++;
			check_isolation(m, sel, 1'b0);
		end while (!(m == 0 ? arready_m0 : arready_m1) && n < wait_limit);
		if (!(m == 0 ? arready_m0 : arready_m1))
			abort_run("arready");
		check_val(sel ? "arid_s1" : "arid_s0", sel ? arid_s1 : arid_s0, {4'(m), id});
		check_val(sel ? "araddr_s1" : "araddr_s0", sel ? araddr_s1 : araddr_s0, addr);
		check_val(sel ? "arlen_s1" : "arlen_s0", sel ? arlen_s1 : arlen_s0, len);
		check_val(sel ? "arsize_s1" : "arsize_s0", sel ? arsize_s1 : arsize_s0, 3'd2);
		check_val(sel ? "arburst_s1" : "arburst_s0", sel ? arburst_s1 : arburst_s0, 2'b01);
		@(posedge ACLK);
		#1;
		arvalid_m0 = (m == 0) ? 1'b0 : arvalid_m0;
		arvalid_m1 = (m == 1) ? 1'b0 : arvalid_m1;
		rready_m0 = (m == 0) ? rand_below(2) : 1'b0;
		rready_m1 = (m == 1) ? rand_below(2) : 1'b0;
		beat = 0;
		n = 0;
		while (beat <= len)
		begin
			@(negedge ACLK);
			n++;
			if (n > wait_limit)
				abort_run("read data");
			check_isolation(m, sel, 1'b0);
			hs = (m == 0) ? (rvalid_m0 && rready_m0) : (rvalid_m1 && rready_m1);
			if (hs)
			begin
				check_val(m == 0 ? "rdata_m0" : "rdata_m1", m == 0 ? rdata_m0 : rdata_m1,
					model_read(sel, addr + 4 * beat));
				check_val(m == 0 ? "rid_m0" : "rid_m1", m == 0 ? rid_m0 : rid_m1, id);
				check_val(m == 0 ? "rresp_m0" : "rresp_m1", m == 0 ? rresp_m0 : rresp_m1,
					`AXI_RESP_OKAY);
				check_val(m == 0 ? "rlast_m0" : "rlast_m1", m == 0 ? rlast_m0 : rlast_m1,
					beat == len);
				beat++;
			end
			@(posedge ACLK);
			#1;
			rready_m0 = (m == 0) ? rand_below(2) : 1'b0;
			rready_m1 = (m == 1) ? rand_below(2) : 1'b0;
		end
		rready_m0 = 1'b0;
		rready_m1 = 1'b0;
	endtask

	task automatic random_txn();
		int kind;
		kind = rand_below(3);
		if (kind == 2)
			write_burst(rand_addr(rand_below(2)), rand_below(16), rand_below(16));
		else
			read_burst(kind, rand_addr(rand_below(2)), rand_below(16), rand_below(16));
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial
	begin
		seed = seed_base;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		ARESETn = 1'b0;
		{arid_m0, araddr_m0, arlen_m0, arsize_m0, arburst_m0, arvalid_m0, rready_m0} = '0;
		{arid_m1, araddr_m1, arlen_m1, arsize_m1, arburst_m1, arvalid_m1, rready_m1} = '0;
		{awid_m1, awaddr_m1, awlen_m1, awsize_m1, awburst_m1, awvalid_m1} = '0;
		{wdata_m1, wstrb_m1, wlast_m1, wvalid_m1, bready_m1} = '0;

		for (int i = 0; i < 8; i++)
		begin
			@(negedge ACLK);
			check_idle_outputs();
		end
		@(posedge ACLK);
		#1;
		ARESETn = 1'b1;
		@(negedge ACLK);
		check_idle_outputs();
		@(posedge ACLK);
		#1;
		finish_test("reset state");

		for (int i = 0; i < 12; i++)
			write_burst(rand_addr(i % 2), rand_below(16), rand_below(16));
		finish_test("write routing");

		for (int i = 0; i < wr_addr.size(); i++)
			read_burst(i % 2, wr_addr[i], rand_below(16), rand_below(wr_len[i] + 1));
		finish_test("read return");

		// Both masters request in the same cycle
		arid_m1 = 4'h9;
		araddr_m1 = wr_addr[1];
		arlen_m1 = 4'd3;
		arvalid_m1 = 1'b1;
		read_burst(0, wr_addr[0], 4'h5, 4'd2);
		read_burst(1, wr_addr[1], 4'h9, 4'd3);
		finish_test("priority");

		for (int i = 0; i < 8; i++)
			random_txn();
		finish_test("isolation");

		for (int i = 0; i < 200; i++)
			random_txn();
		finish_test("mixed random traffic");

		if (stall_err_s0 || stall_err_s1)
		begin
			$display("A slave model timed out waiting on the interconnect");
			total_errors++;
		end
		$display("Tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, total_errors);
		if (total_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- axi_interconnect.f
+incdir+include
hw/axi_ic_pkg.sv
hw/axi_ic_arbiter.sv
hw/axi_ic_read_path.sv
hw/axi_ic_write_path.sv
hw/axi_interconnect.sv
verif/axi_ic_slave_bfm.sv
verif/axi_interconnect_tb.sv
